//--- common/fetch_cfg_pkg.sv
`default_nettype none

package fetch_cfg_pkg;

	// instructions delivered by one cache access
	parameter int unsigned FETCH_NUM = 2;
	parameter int unsigned FETCH_WIDTH = $clog2(FETCH_NUM);

	// byte alignment of a fetch group
	parameter int unsigned ADDR_ALIGN_WIDTH = FETCH_WIDTH + 2;

	// default address after reset
	parameter logic [31:0] BOOT_VEC = 32'hbfc00000;

endpackage

`default_nettype wire

//--- common/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	localparam int unsigned GROUP_NUM = fetch_cfg_pkg::FETCH_NUM;
	localparam int unsigned ALIGN_BITS = fetch_cfg_pkg::ADDR_ALIGN_WIDTH;

	typedef logic [31:0] virt_t;
	typedef logic [31:0] instr_t;

	// slot index inside a fetch group
	typedef logic [fetch_cfg_pkg::FETCH_WIDTH-1:0] offset_t;

	// number of instructions, 0 up to a full group
	typedef logic [$clog2(GROUP_NUM + 1)-1:0] count_t;

	typedef struct packed {
		logic  read;
		virt_t vaddr;
		logic  flush;
	} icache_req_t;

	typedef struct packed {
		logic                      stall;
		logic [GROUP_NUM*32-1:0]   data;
		logic                      iaddr_ex;
	} icache_res_t;

	typedef struct packed {
		logic  valid;
		logic  mispredict;
		virt_t target;
	} branch_resolved_t;

	typedef struct packed {
		logic  taken;
		virt_t target;
	} predict_t;

	typedef struct packed {
		logic     valid;
		virt_t    vaddr;
		instr_t   instr;
		predict_t predict;
		logic     iaddr_ex;
	} fetch_entry_t;

	// pop count returned by decode
	typedef struct packed {
		count_t count;
	} fetch_ack_t;

	// base address of the group holding addr
	function automatic virt_t group_base(input virt_t addr);
		return {addr[31:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
	endfunction

endpackage

`default_nettype wire

//--- logic/pc_generator.sv
`timescale 1ns/1ps
`default_nettype none

module pc_generator #(
	parameter cpu_types_pkg::virt_t RESET_BASE = fetch_cfg_pkg::BOOT_VEC
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            hold_pc,
	input  logic                            except_valid,
	input  cpu_types_pkg::virt_t            except_vec,
	input  logic                            predict_valid,
	input  cpu_types_pkg::virt_t            predict_vaddr,
	input  logic                            predict_delayed,
	input  cpu_types_pkg::branch_resolved_t resolved_branch,
	output cpu_types_pkg::virt_t            pc
);
	import cpu_types_pkg::*;
	import fetch_cfg_pkg::*;

	localparam virt_t GROUP_BYTES = virt_t'(FETCH_NUM * 4);

	logic  pending_valid;
	virt_t pending_vaddr;
	virt_t seq_pc;

	assign seq_pc = group_base(pc) + GROUP_BYTES;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_BASE;
			pending_valid <= 1'b0;
		end else if (except_valid) begin
			pc <= except_vec;
			pending_valid <= 1'b0;
		end else if (resolved_branch.valid && resolved_branch.mispredict) begin
			pc <= resolved_branch.target;
			pending_valid <= 1'b0;
		end else if (hold_pc) begin
			// remember the target until the delay slot goes out
			if (predict_delayed) begin
				pending_valid <= 1'b1;
			end
		end else if (predict_delayed) begin
			// delay-slot group is being requested now
			pc <= predict_vaddr;
			pending_valid <= 1'b0;
		end else if (pending_valid) begin
			pc <= pending_vaddr;
			pending_valid <= 1'b0;
		end else if (predict_valid) begin
			// target group goes out this cycle, continue behind it
			pc <= group_base(predict_vaddr) + GROUP_BYTES;
		end else begin
			pc <= seq_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_pc && predict_delayed) begin
			pending_vaddr <= predict_vaddr;
		end
	end

endmodule

`default_nettype wire

//--- logic/jump_predecoder.sv
`timescale 1ns/1ps
`default_nettype none

module jump_predecoder (
	input  logic                                                     clk,
	input  logic                                                     rst_n,
	input  logic                                                     flush,
	input  logic                                                     hold,
	input  cpu_types_pkg::virt_t                                     pc,
	input  cpu_types_pkg::instr_t   [fetch_cfg_pkg::FETCH_NUM-1:0]   instr,
	input  logic                    [fetch_cfg_pkg::FETCH_NUM-1:0]   instr_valid,
	output logic                                                     valid,
	output logic                                                     delayed,
	output cpu_types_pkg::virt_t                                     predict_vaddr,
	output cpu_types_pkg::count_t                                    keep_num,
	output cpu_types_pkg::predict_t [fetch_cfg_pkg::FETCH_NUM-1:0]   predict
);
	import cpu_types_pkg::*;
	import fetch_cfg_pkg::*;

	typedef enum logic {
		IDLE,
		WAIT_SLOT
	} state_t;

	state_t  state;
	logic    found;
	logic    hit;
	offset_t jump_idx;
	virt_t   link_pc;

	// J and JAL, opcodes 2 and 3
	function automatic logic is_direct_jump(input instr_t word);
		return word[31:27] == 5'b00001;
	endfunction

	always_comb begin
		found = 1'b0;
		jump_idx = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			if (!found && instr_valid[i] && is_direct_jump(instr[i])) begin
				found = 1'b1;
				jump_idx = offset_t'(i);
			end
		end
	end

	// a delay-slot group is passed through unscanned
	assign hit = found && (state == IDLE);

	assign link_pc = pc + virt_t'({jump_idx, 2'b00}) + 32'd4;
	assign predict_vaddr = {link_pc[31:28], instr[jump_idx][25:0], 2'b00};
	assign valid = hit;
	assign delayed = hit && (jump_idx == offset_t'(FETCH_NUM - 1));

	always_comb begin
		keep_num = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			// drop whatever follows the delay slot
			if (instr_valid[i] && (!hit || i <= int'(jump_idx) + 1)) begin
				keep_num = keep_num + 1'b1;
			end
		end
		if (state == WAIT_SLOT) begin
			keep_num = (|instr_valid) ? count_t'(1) : count_t'(0);
		end
	end

	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			predict[i].taken = hit && (jump_idx == offset_t'(i));
			predict[i].target = predict_vaddr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (flush) begin
			state <= IDLE;
		end else if (!hold) begin
			case (state)
				IDLE: begin
					if (delayed) begin
						state <= WAIT_SLOT;
					end
				end
				WAIT_SLOT: begin
					if (|instr_valid) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- instr_queue/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
	parameter int unsigned FIFO_DEPTH = 8
) (
	input  logic                                                         clk,
	input  logic                                                         rst_n,
	input  logic                                                         flush,
	input  logic                                                         stall_push,
	input  cpu_types_pkg::instr_t       [fetch_cfg_pkg::FETCH_NUM-1:0]   instr,
	input  cpu_types_pkg::virt_t        [fetch_cfg_pkg::FETCH_NUM-1:0]   vaddr,
	input  cpu_types_pkg::predict_t     [fetch_cfg_pkg::FETCH_NUM-1:0]   predict,
	input  cpu_types_pkg::count_t                                        valid_num,
	input  cpu_types_pkg::offset_t                                       offset,
	input  logic                                                         iaddr_ex,
	input  cpu_types_pkg::fetch_ack_t                                    fetch_ack,
	output logic                                                         full,
	output cpu_types_pkg::fetch_entry_t [fetch_cfg_pkg::FETCH_NUM-1:0]   fetch_entry
);
	import cpu_types_pkg::*;
	import fetch_cfg_pkg::*;

	// depth is a power of two so the pointers wrap by themselves
	localparam int unsigned PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int unsigned CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	typedef logic [PTR_WIDTH-1:0] ptr_t;
	typedef logic [CNT_WIDTH-1:0] cnt_t;

	fetch_entry_t mem [FIFO_DEPTH];

	ptr_t   rptr;
	ptr_t   wptr;
	cnt_t   count;
	count_t push_num;
	count_t pop_num;

	fetch_entry_t [FETCH_NUM-1:0] in_entry;

	assign push_num = (stall_push || flush) ? count_t'(0) : valid_num;
	assign pop_num = fetch_ack.count;

	// room for one more full group
	assign full = count > cnt_t'(FIFO_DEPTH - FETCH_NUM);

	// line the incoming slots up from the fetch offset
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			in_entry[i] = '0;
			if (int'(offset) + i < FETCH_NUM) begin
				in_entry[i].valid = 1'b1;
				in_entry[i].vaddr = vaddr[int'(offset) + i];
				in_entry[i].instr = instr[int'(offset) + i];
				in_entry[i].predict = predict[int'(offset) + i];
				in_entry[i].iaddr_ex = iaddr_ex;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			if (count_t'(i) < push_num) begin
				mem[ptr_t'(wptr + ptr_t'(i))] <= in_entry[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rptr <= '0;
			wptr <= '0;
			count <= '0;
		end else if (flush) begin
			rptr <= '0;
			wptr <= '0;
			count <= '0;
		end else begin
			wptr <= wptr + ptr_t'(push_num);
			rptr <= rptr + ptr_t'(pop_num);
			count <= count + cnt_t'(push_num) - cnt_t'(pop_num);
		end
	end

	// head window in program order
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			fetch_entry[i] = mem[ptr_t'(rptr + ptr_t'(i))];
			fetch_entry[i].valid = cnt_t'(i) < count;
		end
	end

endmodule

`default_nettype wire

//--- instr_fetch/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
	parameter cpu_types_pkg::virt_t RESET_BASE = fetch_cfg_pkg::BOOT_VEC,
	parameter int unsigned INSTR_FIFO_DEPTH = 8
) (
	input  logic                                                         clk,
	input  logic                                                         rst_n,
	input  logic                                                         flush_pc,
	input  logic                                                         except_valid,
	input  cpu_types_pkg::virt_t                                         except_vec,
	input  cpu_types_pkg::branch_resolved_t                              resolved_branch,
	input  cpu_types_pkg::icache_res_t                                   icache_res,
	output cpu_types_pkg::icache_req_t                                   icache_req,
	input  cpu_types_pkg::fetch_ack_t                                    fetch_ack,
	output cpu_types_pkg::fetch_entry_t [fetch_cfg_pkg::FETCH_NUM-1:0]   fetch_entry
);
	import cpu_types_pkg::*;
	import fetch_cfg_pkg::*;

	// stage 1
	virt_t pc;
	virt_t fetch_vaddr;
	logic  hold_pc;
	logic  pc_freeze;

	// stage 1/2 registers
	virt_t fetch_vaddr_d;
	logic  suppress_push;

	// stage 2
	virt_t   group_vaddr;
	offset_t fetch_offset;
	logic    data_valid;
	logic    queue_full;
	logic    mispredict;
	logic    flush_all;

	instr_t [FETCH_NUM-1:0] instr;
	virt_t  [FETCH_NUM-1:0] instr_vaddr;
	logic   [FETCH_NUM-1:0] instr_valid;

	logic     predict_valid;
	logic     predict_delayed;
	virt_t    predict_vaddr;
	count_t   keep_num;
	predict_t [FETCH_NUM-1:0] predict;

	assign hold_pc = icache_res.stall | queue_full;
	assign mispredict = resolved_branch.valid & resolved_branch.mispredict;
	assign flush_all = flush_pc | mispredict | except_valid;

	// flush_pc restarts from the pc already held
	assign pc_freeze = hold_pc | flush_pc;

	always_comb begin
		if (predict_valid && !predict_delayed && !hold_pc) begin
			fetch_vaddr = predict_vaddr;
		end else if (hold_pc && !suppress_push) begin
			// stall or full queue, ask for the same group again
			fetch_vaddr = fetch_vaddr_d;
		end else begin
			fetch_vaddr = pc;
		end
	end

	assign icache_req.read = 1'b1;
	assign icache_req.vaddr = group_base(fetch_vaddr);
	assign icache_req.flush = flush_all;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_vaddr_d <= '0;
			suppress_push <= 1'b1;
		end else if (flush_all) begin
			fetch_vaddr_d <= '0;
			suppress_push <= 1'b1;
		end else begin
			if (!hold_pc) begin
				fetch_vaddr_d <= fetch_vaddr;
			end
			// stays set until a fresh request has gone out
			suppress_push <= suppress_push & hold_pc;
		end
	end

	assign group_vaddr = group_base(fetch_vaddr_d);
	assign fetch_offset = fetch_vaddr_d[ADDR_ALIGN_WIDTH-1 -: FETCH_WIDTH];
	assign data_valid = ~icache_res.stall & ~suppress_push & ~flush_all;

	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			instr[i] = icache_res.data[i*32 +: 32];
			instr_vaddr[i] = group_vaddr + virt_t'(i * 4);
			instr_valid[i] = data_valid && (i >= int'(fetch_offset));
		end
	end

	pc_generator #(
		.RESET_BASE ( RESET_BASE )
	) u_pc_generator (
		.clk,
		.rst_n,
		.hold_pc         ( pc_freeze       ),
		.except_valid,
		.except_vec,
		.predict_valid,
		.predict_vaddr,
		.predict_delayed,
		.resolved_branch,
		.pc
	);

	jump_predecoder u_jump_predecoder (
		.clk,
		.rst_n,
		.flush         ( flush_all       ),
		.hold          ( hold_pc         ),
		.pc            ( group_vaddr     ),
		.instr,
		.instr_valid,
		.valid         ( predict_valid   ),
		.delayed       ( predict_delayed ),
		.predict_vaddr,
		.keep_num,
		.predict
	);

	instr_queue #(
		.FIFO_DEPTH ( INSTR_FIFO_DEPTH )
	) u_instr_queue (
		.clk,
		.rst_n,
		.flush      ( flush_all           ),
		.stall_push ( hold_pc             ),
		.instr,
		.vaddr      ( instr_vaddr         ),
		.predict,
		.valid_num  ( keep_num            ),
		.offset     ( fetch_offset        ),
		.iaddr_ex   ( icache_res.iaddr_ex ),
		.fetch_ack,
		.full       ( queue_full          ),
		.fetch_entry
	);

endmodule

`default_nettype wire

//--- test/instr_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch_tb;
	import cpu_types_pkg::*;
	import fetch_cfg_pkg::*;

	localparam int WAIT_LIMIT = 3000;
	localparam int KIND_START = 0;
	localparam int KIND_MISPREDICT = 1;
	localparam int KIND_EXCEPTION = 2;

	logic             clk = 1'b0;
	logic             rst_n = 1'b0;
	logic             flush_pc = 1'b0;
	logic             except_valid = 1'b0;
	virt_t            except_vec = '0;
	branch_resolved_t resolved_branch = '0;
	icache_res_t      icache_res = '0;
	icache_req_t      icache_req;
	fetch_ack_t       fetch_ack = '0;
	fetch_entry_t [FETCH_NUM-1:0] fetch_entry;

	integer       seed = 9576;
	fetch_entry_t exp_q[$];
	virt_t        req_addr = '0;
	int           err_count = 0;
	int           timeout_count = 0;
	int           tests_failed = 0;
	int           redir_seq = 0;
	int           redir_done = 0;
	int           redir_kind = KIND_START;
	virt_t        redir_target = '0;
	int           redir_len = 0;
	int           redir_zero = 0;
	int           zero_run = 0;
	logic         stall_en = 1'b0;
	logic         stream_start = 1'b0;
	logic         flush_expected = 1'b0;
	logic         was_flush = 1'b1;

	instr_fetch #(
		.RESET_BASE       ( BOOT_VEC ),
		.INSTR_FIFO_DEPTH ( 8        )
	) u_instr_fetch (
		.clk             ( clk             ),
		.rst_n           ( rst_n           ),
		.flush_pc        ( flush_pc        ),
		.except_valid    ( except_valid    ),
		.except_vec      ( except_vec      ),
		.resolved_branch ( resolved_branch ),
		.icache_res      ( icache_res      ),
		.icache_req      ( icache_req      ),
		.fetch_ack       ( fetch_ack       ),
		.fetch_entry     ( fetch_entry     )
	);

	initial begin
		forever #50 clk = ~clk;
	end

	function automatic instr_t jump_word(input logic [5:0] opcode, input virt_t target);
		return {opcode, target[27:2]};
	endfunction

	// ADDIU everywhere except a few direct jumps
	function automatic instr_t cache_word(input virt_t addr);
		case (addr)
			32'hbfc01008: return jump_word(6'd2, 32'hbfc01100);
			32'hbfc0110c: return jump_word(6'd3, 32'hbfc01204);
			32'hbfc01230: return jump_word(6'd2, 32'hbfc01000);
			default: return {6'h09, addr[31:22] ^ addr[21:12], addr[17:2] ^ addr[31:16]};
		endcase
	endfunction

	// one group of the image raises the fetch exception flag
	function automatic logic fetch_fault(input virt_t addr);
		return (addr >> ADDR_ALIGN_WIDTH) == (32'hbfc00390 >> ADDR_ALIGN_WIDTH);
	endfunction

	// program order from start where a taken jump keeps its delay slot
	function automatic void expected_stream(input virt_t start, input int len);
		fetch_entry_t e;
		virt_t        addr;
		virt_t        next_addr;
		virt_t        target;
		logic         in_delay;
		addr = start;
		target = '0;
		in_delay = 1'b0;
		for (int n = 0; n < len; n++) begin
			e = '0;
			e.valid = 1'b1;
			e.vaddr = addr;
			e.instr = cache_word(addr);
			e.iaddr_ex = fetch_fault(addr);
			if (in_delay) begin
				next_addr = target;
				in_delay = 1'b0;
			end else begin
				next_addr = addr + 32'd4;
				if (e.instr[31:26] == 6'd2 || e.instr[31:26] == 6'd3) begin
					target = {next_addr[31:28], e.instr[25:0], 2'b00};
					e.predict.taken = 1'b1;
					e.predict.target = target;
					in_delay = 1'b1;
				end
			end
			exp_q.push_back(e);
			addr = next_addr;
		end
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		err_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("failure at %0t ns: %s", $time, msg);
		err_count++;
	endtask

	task automatic check_entry(input fetch_entry_t got);
		fetch_entry_t exp;
		if (exp_q.size() == 0) begin
			report_failure("decode popped an entry beyond the reference stream");
		end else begin
			exp = exp_q.pop_front();
			if (got.vaddr !== exp.vaddr)
				report_value("fetch_entry.vaddr", exp.vaddr, got.vaddr);
			if (got.instr !== exp.instr)
				report_value("fetch_entry.instr", exp.instr, got.instr);
			if (got.predict.taken !== exp.predict.taken)
				report_value("fetch_entry.predict.taken", exp.predict.taken, got.predict.taken);
			if (exp.predict.taken && got.predict.target !== exp.predict.target)
				report_value("fetch_entry.predict.target", exp.predict.target, got.predict.target);
			if (got.iaddr_ex !== exp.iaddr_ex)
				report_value("fetch_entry.iaddr_ex", exp.iaddr_ex, got.iaddr_ex);
		end
	endtask

	task automatic check_cycle();
		logic any_valid;
		any_valid = 1'b0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			any_valid = any_valid | fetch_entry[i].valid;
		end
		if (icache_req.read !== 1'b1)
			report_value("icache_req.read", 32'd1, icache_req.read);
		if (icache_req.vaddr[ADDR_ALIGN_WIDTH-1:0] !== '0)
			report_value("icache_req.vaddr low bits", 32'd0,
				icache_req.vaddr[ADDR_ALIGN_WIDTH-1:0]);
		if (icache_req.flush !== flush_expected)
			report_value("icache_req.flush", flush_expected, icache_req.flush);
		if (was_flush && any_valid)
			report_failure("valid entries at the queue head right after a reset or flush");
		was_flush = !rst_n || flush_expected;
		for (int i = 0; i < int'(fetch_ack.count); i++) begin
			check_entry(fetch_entry[i]);
		end
		if (stream_start) begin
			exp_q.delete();
			expected_stream(redir_target, redir_len);
		end
	endtask

	// cache answers last cycle's request and decode acks a random count
	task automatic drive_inputs();
		int valid_num;
		int limit;
		icache_res.stall = stall_en && (($random(seed) & 3) == 0);
		icache_res.iaddr_ex = fetch_fault(req_addr);
		for (int i = 0; i < FETCH_NUM; i++) begin
			icache_res.data[i*32 +: 32] = cache_word(req_addr + virt_t'(i * 4));
		end
		except_valid = 1'b0;
		except_vec = '0;
		resolved_branch = '0;
		stream_start = 1'b0;
		flush_expected = 1'b0;
		valid_num = 0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			if (fetch_entry[i].valid)
				valid_num++;
		end
		limit = (valid_num < exp_q.size()) ? valid_num : exp_q.size();
		if (rst_n && redir_done != redir_seq) begin
			if (redir_kind == KIND_MISPREDICT) begin
				resolved_branch.valid = 1'b1;
				resolved_branch.mispredict = 1'b1;
				resolved_branch.target = redir_target;
			end else if (redir_kind == KIND_EXCEPTION) begin
				except_valid = 1'b1;
				except_vec = redir_target;
			end
			flush_expected = (redir_kind != KIND_START);
			stream_start = 1'b1;
			zero_run = redir_zero;
			redir_done = redir_seq;
			fetch_ack.count = '0;
		end else if (zero_run > 0) begin
			zero_run--;
			fetch_ack.count = '0;
		end else begin
			fetch_ack.count = count_t'(($random(seed) & 32'h7fff) % (limit + 1));
		end
	endtask

	always @(posedge clk) begin
		#1;
		drive_inputs();
	end

	// request of this cycle is answered after the next edge
	always @(negedge clk) begin
		req_addr = icache_req.vaddr;
		check_cycle();
	end

	task automatic run_test(input int num, input string name, input int kind,
			input virt_t target, input int len, input logic stalls, input int zeros);
		int   errors_before;
		int   cycles;
		logic timed_out;
		errors_before = err_count;
		stall_en = stalls;
		redir_kind = kind;
		redir_target = target;
		redir_len = len;
		redir_zero = zeros;
		redir_seq++;
		cycles = 0;
		while ((redir_done != redir_seq || exp_q.size() != 0) && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		timed_out = (redir_done != redir_seq) || (exp_q.size() != 0);
		if (timed_out) begin
			timeout_count++;
			$display("test %0d timed out with %0d words never delivered", num, exp_q.size());
		end
		if (!timed_out && err_count == errors_before) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", num, name);
		end
	endtask

	initial begin
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		run_test(1, "reset and straight-line code", KIND_START, BOOT_VEC, 24, 1'b0, 0);
		run_test(2, "jumps in slot 0 and the last slot", KIND_MISPREDICT,
			32'hbfc01000, 24, 1'b0, 0);
		run_test(3, "random stalls and acks", KIND_MISPREDICT, 32'hbfc01000, 80, 1'b1, 20);
		// no acks for a while so the flush hits a full queue
		repeat (12) @(posedge clk);
		run_test(4, "mispredict flush", KIND_MISPREDICT, 32'hbfc02000, 16, 1'b1, 0);
		run_test(5, "exception redirect", KIND_EXCEPTION, 32'hbfc00380, 16, 1'b1, 0);
		run_test(6, "unaligned redirect target", KIND_MISPREDICT, 32'hbfc03004, 12, 1'b1, 0);
		@(posedge clk);
		$display("tests run 6, tests failed %0d, check errors %0d, timeouts %0d",
			tests_failed, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
common/fetch_cfg_pkg.sv
common/cpu_types_pkg.sv
logic/pc_generator.sv
logic/jump_predecoder.sv
instr_queue/instr_queue.sv
instr_fetch/instr_fetch.sv
test/instr_fetch_tb.sv
